//--- Bender.yml
package:
  name: cpu_top

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/register_file.sv
      - rtl/unified_ram.sv
      - rtl/exec_unit.sv
      - rtl/cpu_top.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cpu_top_tb.sv

//--- cpu_top.f
+incdir+sim
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/unified_ram.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
sim/cpu_top_tb.sv

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // Datapath widths
    localparam int data_bits     = 8;
    localparam int addr_bits     = 8;
    localparam int reg_addr_bits = 3;
    localparam int num_regs      = 8;
    localparam int instr_bits    = 16;

    typedef enum logic [3:0] {
        op_movi  = 4'd0,
        op_load  = 4'd2,
        op_store = 4'd3,
        op_addr  = 4'd4,
        op_addi  = 4'd5,
        op_subr  = 4'd6,
        op_subi  = 4'd7,
        op_jnz   = 4'd8,
        op_jz    = 4'd9,
        op_nop   = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_start,
        st_fetch_end,
        st_reg_fetch,
        st_execute,
        st_reg_wb,
        st_load,
        st_store
    } exec_stage_t;

    // Instruction fields, high byte at the even address
    localparam int op_msb  = 15;
    localparam int op_lsb  = 12;
    localparam int rd_msb  = 10;
    localparam int rd_lsb  = 8;
    localparam int imm_msb = 7;
    localparam int imm_lsb = 0;
    localparam int rs1_msb = 6;
    localparam int rs1_lsb = 4;
    localparam int rs2_msb = 2;
    localparam int rs2_lsb = 0;

endpackage

//--- rtl/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           run,
    input  logic                           load_en,
    input  logic [cpu_pkg::addr_bits-1:0]  load_addr,
    input  logic [cpu_pkg::data_bits-1:0]  load_data,
    output logic                           store_en,
    output logic [cpu_pkg::addr_bits-1:0]  store_addr,
    output logic [cpu_pkg::data_bits-1:0]  store_data
);

    import cpu_pkg::*;

    logic [addr_bits-1:0]     mem_rd_addr;
    logic [data_bits-1:0]     mem_rd_data;
    logic                     mem_wr_en;
    logic [addr_bits-1:0]     mem_wr_addr;
    logic [data_bits-1:0]     mem_wr_data;

    logic [reg_addr_bits-1:0] rf_rd0_addr;
    logic [reg_addr_bits-1:0] rf_rd1_addr;
    logic [data_bits-1:0]     rf_rd0_data;
    logic [data_bits-1:0]     rf_rd1_data;
    logic                     rf_wr_en;
    logic [reg_addr_bits-1:0] rf_wr_addr;
    logic [data_bits-1:0]     rf_wr_data;

    exec_unit exec_unit_i (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .rd_addr     (mem_rd_addr),
        .rd_data     (mem_rd_data),
        .wr_en       (mem_wr_en),
        .wr_addr     (mem_wr_addr),
        .wr_data     (mem_wr_data),
        .rf_rd0_addr (rf_rd0_addr),
        .rf_rd1_addr (rf_rd1_addr),
        .rd0_data    (rf_rd0_data),
        .rd1_data    (rf_rd1_data),
        .rf_wr_en    (rf_wr_en),
        .rf_wr_addr  (rf_wr_addr),
        .rf_wr_data  (rf_wr_data)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rd0_addr (rf_rd0_addr),
        .rd1_addr (rf_rd1_addr),
        .wr_en    (rf_wr_en),
        .wr_addr  (rf_wr_addr),
        .wr_data  (rf_wr_data),
        .rd0_data (rf_rd0_data),
        .rd1_data (rf_rd1_data)
    );

    unified_ram unified_ram_i (
        .clk       (clk),
        .rd_addr   (mem_rd_addr),
        .rd_data   (mem_rd_data),
        .wr_en     (mem_wr_en),
        .wr_addr   (mem_wr_addr),
        .wr_data   (mem_wr_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // Core writes are also visible outside as the store port
    assign store_en   = mem_wr_en;
    assign store_addr = mem_wr_addr;
    assign store_data = mem_wr_data;

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               run,

    output logic [cpu_pkg::addr_bits-1:0]      rd_addr,
    input  logic [cpu_pkg::data_bits-1:0]      rd_data,

    output logic                               wr_en,
    output logic [cpu_pkg::addr_bits-1:0]      wr_addr,
    output logic [cpu_pkg::data_bits-1:0]      wr_data,

    output logic [cpu_pkg::reg_addr_bits-1:0]  rf_rd0_addr,
    output logic [cpu_pkg::reg_addr_bits-1:0]  rf_rd1_addr,
    input  logic [cpu_pkg::data_bits-1:0]      rd0_data,
    input  logic [cpu_pkg::data_bits-1:0]      rd1_data,
    output logic                               rf_wr_en,
    output logic [cpu_pkg::reg_addr_bits-1:0]  rf_wr_addr,
    output logic [cpu_pkg::data_bits-1:0]      rf_wr_data
);

    import cpu_pkg::*;

    typedef enum logic {
        b_sel_reg,
        b_sel_imm
    } alu_b_sel_t;

    typedef enum logic [1:0] {
        wd_alu,
        wd_imm,
        wd_mem
    } wr_data_sel_t;

    exec_stage_t          stage;
    opcode_t              op;
    opcode_t              ir_op;
    logic [addr_bits-1:0] pc;
    logic [instr_bits-1:0] ir;
    logic [data_bits-1:0] imm;

    logic                 zero_flag;
    logic                 save_flags;
    logic                 subtract;
    logic                 is_arith;
    logic                 ir_two_src;
    alu_b_sel_t           alu_b_sel;
    wr_data_sel_t         wr_sel;

    logic [data_bits-1:0] alu_b;
    logic [data_bits-1:0] alu_sum;
    logic [data_bits-1:0] alu_result;

    // Opcode field of the fetched instruction, undefined codes become nop
    always_comb begin
        case (ir[op_msb:op_lsb])
            op_movi, op_load, op_store,
            op_addr, op_addi, op_subr, op_subi,
            op_jnz, op_jz: begin
                ir_op = opcode_t'(ir[op_msb:op_lsb]);
            end
            default: begin
                ir_op = op_nop;
            end
        endcase
    end

    assign ir_two_src = (ir_op == op_addr) || (ir_op == op_subr);

    // Register reads follow the instruction register directly,
    // so jz can use the destination register already in register fetch
    assign rf_rd0_addr = ir_two_src ? ir[rs1_msb:rs1_lsb] : ir[rd_msb:rd_lsb];
    assign rf_rd1_addr = ir[rs2_msb:rs2_lsb];

    assign is_arith = (op == op_addr) || (op == op_addi) ||
                      (op == op_subr) || (op == op_subi);

    // Single adder; subtraction is a + ~b + 1
    assign alu_b   = (alu_b_sel == b_sel_imm) ? imm : rd1_data;
    assign alu_sum = rd0_data + (subtract ? ~alu_b : alu_b) + data_bits'(subtract);

    // Memory read address per stage
    always_comb begin
        case (stage)
            st_fetch_end: rd_addr = pc + addr_bits'(1);
            st_load:      rd_addr = imm;
            default:      rd_addr = pc;
        endcase
    end

    // Register write strobe and data select
    assign rf_wr_en = ((stage == st_execute) && (op == op_movi)) ||
                      (stage == st_reg_wb) ||
                      (stage == st_load);

    always_comb begin
        case (wr_sel)
            wd_imm:  rf_wr_data = imm;
            wd_mem:  rf_wr_data = rd_data;
            default: rf_wr_data = alu_result;
        endcase
    end

    // Stage sequencer, decode, flags and program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage      <= st_idle;
            op         <= op_nop;
            pc         <= '0;
            zero_flag  <= 1'b0;
            save_flags <= 1'b0;
            subtract   <= 1'b0;
            alu_b_sel  <= b_sel_reg;
            wr_sel     <= wd_alu;
            wr_en      <= 1'b0;
        end else begin
            case (stage)
                st_idle: begin
                    if (run) begin
                        stage <= st_fetch_start;
                    end
                end
                st_fetch_start: begin
                    // Flags of the previous arithmetic instruction land here
                    if (save_flags) begin
                        zero_flag <= (alu_result == '0);
                    end
                    save_flags <= 1'b0;
                    stage      <= run ? st_fetch_end : st_idle;
                end
                st_fetch_end: begin
                    stage <= st_reg_fetch;
                end
                st_reg_fetch: begin
                    op        <= ir_op;
                    subtract  <= (ir_op == op_subr) || (ir_op == op_subi);
                    alu_b_sel <= ir_two_src ? b_sel_reg : b_sel_imm;

                    case (ir_op)
                        op_movi: wr_sel <= wd_imm;
                        op_load: wr_sel <= wd_mem;
                        default: wr_sel <= wd_alu;
                    endcase

                    // Jumps resolve here so the next fetch uses the target
                    if ((ir_op == op_jnz) && !zero_flag) begin
                        pc <= ir[imm_msb:imm_lsb];
                    end else if ((ir_op == op_jz) && zero_flag) begin
                        pc <= rd0_data;
                    end else begin
                        pc <= pc + addr_bits'(2);
                    end

                    stage <= st_execute;
                end
                st_execute: begin
                    save_flags <= is_arith;
                    wr_en      <= (op == op_store);

                    if (op == op_load) begin
                        stage <= st_load;
                    end else if (op == op_store) begin
                        stage <= st_store;
                    end else if (is_arith) begin
                        stage <= st_reg_wb;
                    end else begin
                        stage <= st_fetch_start;
                    end
                end
                st_reg_wb, st_load: begin
                    stage <= st_fetch_start;
                end
                st_store: begin
                    wr_en <= 1'b0;
                    stage <= st_fetch_start;
                end
                default: begin
                    stage <= st_idle;
                end
            endcase
        end
    end

    // Instruction and operand registers
    always_ff @(posedge clk) begin
        case (stage)
            st_fetch_start: begin
                ir[instr_bits-1:data_bits] <= rd_data;
            end
            st_fetch_end: begin
                ir[data_bits-1:0] <= rd_data;
            end
            st_reg_fetch: begin
                imm        <= ir[imm_msb:imm_lsb];
                rf_wr_addr <= ir[rd_msb:rd_lsb];
            end
            st_execute: begin
                alu_result <= alu_sum;
                // Store operands, written out during the store stage
                wr_addr    <= imm;
                wr_data    <= rd0_data;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [cpu_pkg::reg_addr_bits-1:0]  rd0_addr,
    input  logic [cpu_pkg::reg_addr_bits-1:0]  rd1_addr,
    input  logic                               wr_en,
    input  logic [cpu_pkg::reg_addr_bits-1:0]  wr_addr,
    input  logic [cpu_pkg::data_bits-1:0]      wr_data,
    output logic [cpu_pkg::data_bits-1:0]      rd0_data,
    output logic [cpu_pkg::data_bits-1:0]      rd1_data
);

    import cpu_pkg::*;

    logic [data_bits-1:0] regs [num_regs];

    // All registers start from zero so programs see a known state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the old value during a write cycle
    assign rd0_data = regs[rd0_addr];
    assign rd1_data = regs[rd1_addr];

endmodule

//--- rtl/unified_ram.sv
`timescale 1ns/1ns

module unified_ram (
    input  logic                           clk,
    input  logic [cpu_pkg::addr_bits-1:0]  rd_addr,
    output logic [cpu_pkg::data_bits-1:0]  rd_data,
    input  logic                           wr_en,
    input  logic [cpu_pkg::addr_bits-1:0]  wr_addr,
    input  logic [cpu_pkg::data_bits-1:0]  wr_data,
    input  logic                           load_en,
    input  logic [cpu_pkg::addr_bits-1:0]  load_addr,
    input  logic [cpu_pkg::data_bits-1:0]  load_data
);

    import cpu_pkg::*;

    localparam int depth = 2 ** addr_bits;

    // Program and data share this array
    logic [data_bits-1:0] mem [depth];

    // Load port wins; it is only used while the core is stopped
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

//--- sim/tb_programs.svh
`ifndef tb_programs_svh
`define tb_programs_svh

localparam int num_tests      = 6;
localparam int max_bytes      = 32;
localparam int max_stores     = 4;
localparam int countdown_from = 3;

string      test_name   [num_tests];
logic [7:0] image       [num_tests][max_bytes];
int         store_count [num_tests];
logic [7:0] exp_addr    [num_tests][max_stores];
logic [7:0] exp_data    [num_tests][max_stores];

// Immediate form, also used for load, store and the jumps
function automatic logic [15:0] encode_imm(logic [3:0] op, logic [2:0] rd, logic [7:0] imm);
    return {op, 1'b0, rd, imm};
endfunction

function automatic logic [15:0] encode_regs(logic [3:0] op, logic [2:0] rd,
                                            logic [2:0] rs1, logic [2:0] rs2);
    return {op, 1'b0, rd, 1'b0, rs1, 1'b0, rs2};
endfunction

// High byte at the even address
task automatic place_word(int t, int addr, logic [15:0] word);
    image[t][addr]     = word[15:8];
    image[t][addr + 1] = word[7:0];
endtask

// Clears the zero flag, then spins on a jnz to itself
task automatic place_idle_loop(int t, int addr);
    place_word(t, addr, encode_imm(op_addi, 3'd7, 8'd1));
    place_word(t, addr + 2, encode_imm(op_jnz, 3'd0, 8'(addr + 2)));
endtask

task automatic expect_store(int t, logic [7:0] addr, logic [7:0] data);
    exp_addr[t][store_count[t]] = addr;
    exp_data[t][store_count[t]] = data;
    store_count[t]++;
endtask

task automatic build_programs();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] data_byte;
    logic [7:0] offset;

    for (int t = 0; t < num_tests; t++) begin
        store_count[t] = 0;
        for (int i = 0; i < max_bytes; i++) begin
            image[t][i] = '0;
        end
    end

    test_name[0] = "mov_store";
    place_word(0, 0, encode_imm(op_movi, 3'd1, 8'ha5));
    place_word(0, 2, encode_imm(op_store, 3'd1, 8'h40));
    place_word(0, 4, encode_imm(op_movi, 3'd2, 8'h3c));
    place_word(0, 6, encode_imm(op_store, 3'd2, 8'h41));
    place_idle_loop(0, 8);
    expect_store(0, 8'h40, 8'ha5);
    expect_store(0, 8'h41, 8'h3c);

    test_name[1] = "arith_random";
    a = 8'($urandom);
    b = 8'($urandom);
    c = 8'($urandom);
    place_word(1, 0, encode_imm(op_movi, 3'd1, a));
    place_word(1, 2, encode_imm(op_movi, 3'd2, b));
    place_word(1, 4, encode_regs(op_addr, 3'd3, 3'd1, 3'd2));
    place_word(1, 6, encode_imm(op_store, 3'd3, 8'h50));
    place_word(1, 8, encode_regs(op_subr, 3'd4, 3'd1, 3'd2));
    place_word(1, 10, encode_imm(op_store, 3'd4, 8'h51));
    place_word(1, 12, encode_imm(op_addi, 3'd1, c));
    place_word(1, 14, encode_imm(op_store, 3'd1, 8'h52));
    place_word(1, 16, encode_imm(op_subi, 3'd2, c));
    place_word(1, 18, encode_imm(op_store, 3'd2, 8'h53));
    place_idle_loop(1, 20);
    expect_store(1, 8'h50, 8'(a + b));
    expect_store(1, 8'h51, 8'(a - b));
    expect_store(1, 8'h52, 8'(a + c));
    expect_store(1, 8'h53, 8'(b - c));

    // Data byte sits in the image past the code
    test_name[2] = "load_add";
    data_byte = 8'h9c;
    offset    = 8'h25;
    image[2][30] = data_byte;
    place_word(2, 0, encode_imm(op_load, 3'd1, 8'd30));
    place_word(2, 2, encode_imm(op_addi, 3'd1, offset));
    place_word(2, 4, encode_imm(op_store, 3'd1, 8'h60));
    place_idle_loop(2, 6);
    expect_store(2, 8'h60, 8'(data_byte + offset));

    test_name[3] = "jnz_countdown";
    place_word(3, 0, encode_imm(op_movi, 3'd1, 8'(countdown_from)));
    place_word(3, 2, encode_imm(op_store, 3'd1, 8'h70));
    place_word(3, 4, encode_imm(op_subi, 3'd1, 8'd1));
    place_word(3, 6, encode_imm(op_jnz, 3'd0, 8'd2));
    place_idle_loop(3, 8);
    for (int n = countdown_from; n > 0; n--) begin
        expect_store(3, 8'h70, 8'(n));
    end

    // First jz is taken over the store at 8, the second one falls through
    test_name[4] = "jz_skip";
    place_word(4, 0, encode_imm(op_movi, 3'd1, 8'd5));
    place_word(4, 2, encode_imm(op_movi, 3'd5, 8'd10));
    place_word(4, 4, encode_imm(op_subi, 3'd1, 8'd5));
    place_word(4, 6, encode_imm(op_jz, 3'd5, 8'd0));
    place_word(4, 8, encode_imm(op_store, 3'd1, 8'h80));
    place_word(4, 10, encode_imm(op_movi, 3'd2, 8'd7));
    place_word(4, 12, encode_imm(op_movi, 3'd6, 8'd8));
    place_word(4, 14, encode_imm(op_subi, 3'd2, 8'd3));
    place_word(4, 16, encode_imm(op_jz, 3'd6, 8'd0));
    place_word(4, 18, encode_imm(op_store, 3'd2, 8'h81));
    place_idle_loop(4, 20);
    expect_store(4, 8'h81, 8'd4);

    // Both undefined words name r1 as destination
    test_name[5] = "undefined_opcode";
    place_word(5, 0, encode_imm(op_movi, 3'd1, 8'h5a));
    place_word(5, 2, 16'h11ff);
    place_word(5, 4, 16'he1c7);
    place_word(5, 6, encode_imm(op_store, 3'd1, 8'h90));
    place_idle_loop(5, 8);
    expect_store(5, 8'h90, 8'h5a);
endtask

`endif

//--- sim/cpu_top_tb.sv
`timescale 1ns/1ns

module cpu_top_tb;

    import cpu_pkg::*;

    localparam int store_timeout = 200;
    localparam int quiet_cycles  = 60;
    localparam int mem_bytes     = 2 ** addr_bits;

    logic                 clk;
    logic                 reset;
    logic                 run;
    logic                 load_en;
    logic [addr_bits-1:0] load_addr;
    logic [data_bits-1:0] load_data;
    logic                 store_en;
    logic [addr_bits-1:0] store_addr;
    logic [data_bits-1:0] store_data;

    int tests_passed;
    int tests_failed;

    `include "tb_programs.svh"

    cpu_top cpu_top_i (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    always #50 clk = ~clk;

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    // One byte per cycle through the load port
    task automatic write_byte(int addr, logic [7:0] data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = 8'(addr);
        load_data = data;
    endtask

    task automatic clear_memory();
        for (int i = 0; i < mem_bytes; i++) begin
            write_byte(i, 8'h00);
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic load_image(int t);
        for (int i = 0; i < max_bytes; i++) begin
            write_byte(i, image[t][i]);
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // Store strobe lasts one full cycle, so the falling edge sees it once
    task automatic wait_for_store(int limit, output bit seen,
                                  output logic [7:0] addr, output logic [7:0] data);
        int cycles;
        seen   = 1'b0;
        addr   = '0;
        data   = '0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            if (store_en) begin
                seen = 1'b1;
                addr = store_addr;
                data = store_data;
            end
            cycles++;
        end
    endtask

    task automatic run_test(int t);
        bit         seen;
        bit         failed;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] last_addr;
        logic [7:0] last_data;
        int         k;
        failed    = 1'b0;
        last_addr = '0;
        last_data = '0;
        clear_memory();
        load_image(t);
        apply_reset();
        @(negedge clk);
        run = 1'b1;
        k = 0;
        while (!failed && k < store_count[t]) begin
            wait_for_store(store_timeout, seen, addr, data);
            if (!seen) begin
                $display("Test %s: store %0d of %0d to address %h never came within %0d cycles",
                         test_name[t], k + 1, store_count[t], exp_addr[t][k], store_timeout);
                failed = 1'b1;
            end else if (addr !== exp_addr[t][k] || data !== exp_data[t][k]) begin
                $display("Fail %s: store %0d expected addr %h data %h, actual addr %h data %h",
                         test_name[t], k + 1, exp_addr[t][k], exp_data[t][k], addr, data);
                failed = 1'b1;
            end else begin
                last_addr = addr;
                last_data = data;
            end
            k++;
        end
        if (!failed) begin
            wait_for_store(quiet_cycles, seen, addr, data);
            if (seen) begin
                $display("Test %s: an extra store to %h with data %h came after the last one",
                         test_name[t], addr, data);
                failed = 1'b1;
            end
        end
        if (failed) begin
            tests_failed++;
        end else begin
            tests_passed++;
            $display("pass %s: %0d stores, last expected addr %h data %h, actual addr %h data %h",
                     test_name[t], store_count[t], exp_addr[t][store_count[t] - 1],
                     exp_data[t][store_count[t] - 1], last_addr, last_data);
        end
        // Core drops back to idle at its next fetch
        run = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        run          = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(88));
        build_programs();
        apply_reset();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 num_tests, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
